// ==== rtl/preview_pkg.sv ====
`default_nettype none

package preview_pkg;

    // region of interest
    localparam int ROI_WIDTH    = 8;
    localparam int ROI_HEIGHT   = 4;
    localparam int FRAME_PIXELS = ROI_WIDTH * ROI_HEIGHT;
    localparam int POS_WIDTH    = 16;
    localparam int PIXEL_WIDTH  = 8;

    // host command words
    localparam int CMD_BYTES       = 6;
    localparam int CMD_ADDR_WIDTH  = 16;
    localparam int CMD_DATA_WIDTH  = 32;
    localparam int CMD_COUNT_WIDTH = $clog2(CMD_BYTES);

    // "BIVFRAME" with 'B' leaving first
    localparam logic [63:0] MAGIC_NUM = 64'h42_49_56_46_52_41_4D_45;
    localparam int MAGIC_BYTES      = 8;
    localparam int HDR_INDEX_WIDTH  = $clog2(MAGIC_BYTES);

    // contrast constants with gain in unsigned 4.4
    localparam int GAIN_FRAC_BITS = 4;
    localparam logic [PIXEL_WIDTH-1:0] DEFAULT_GAIN = 8'd16;
    localparam logic [PIXEL_WIDTH-1:0] DEFAULT_BIAS = 8'd0;

    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

    typedef enum logic [CMD_ADDR_WIDTH-1:0] {
        REG_GAIN = 16'h0001,
        REG_BIAS = 16'h0002
    } cmd_addr_e;

    typedef enum logic {
        HEADER,
        PIXELS
    } ser_state_e;

endpackage

`default_nettype wire

// ==== rtl/word_concatenator.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_concatenator (
    input  logic                                     core_clk,
    input  logic                                     sys_reset,
    input  logic [preview_pkg::PIXEL_WIDTH-1:0]      byte_i,
    input  logic                                     byte_valid_i,
    output logic [preview_pkg::CMD_ADDR_WIDTH-1:0]   addr_o,
    output logic [preview_pkg::CMD_DATA_WIDTH-1:0]   data_o,
    output logic                                     word_valid_o
);
    import preview_pkg::*;

    logic [CMD_ADDR_WIDTH+CMD_DATA_WIDTH-1:0] shift_q;
    logic [CMD_COUNT_WIDTH-1:0]               count_q;

    // bytes arrive msb first, so older bytes move up
    always_ff @(posedge core_clk) begin
        if (byte_valid_i) begin
            shift_q <= {shift_q[CMD_ADDR_WIDTH+CMD_DATA_WIDTH-PIXEL_WIDTH-1:0], byte_i};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            count_q      <= '0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= 1'b0;
            if (byte_valid_i) begin
                if (count_q == CMD_COUNT_WIDTH'(CMD_BYTES - 1)) begin
                    count_q      <= '0;
                    word_valid_o <= 1'b1;
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end
        end
    end

    // whole word sits in the shift register during the pulse
    assign addr_o = shift_q[CMD_ADDR_WIDTH+CMD_DATA_WIDTH-1:CMD_DATA_WIDTH];
    assign data_o = shift_q[CMD_DATA_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== rtl/constants_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module constants_controller (
    input  logic                                     core_clk,
    input  logic                                     sys_reset,
    input  logic [preview_pkg::CMD_ADDR_WIDTH-1:0]   addr_i,
    input  logic [preview_pkg::CMD_DATA_WIDTH-1:0]   data_i,
    input  logic                                     word_valid_i,
    output logic [preview_pkg::PIXEL_WIDTH-1:0]      gain_o,
    output logic [preview_pkg::PIXEL_WIDTH-1:0]      bias_o
);
    import preview_pkg::*;

    cmd_addr_e reg_addr;

    assign reg_addr = cmd_addr_e'(addr_i);

    //////////////////////////////
    // register file
    //////////////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            gain_o <= DEFAULT_GAIN;
            bias_o <= DEFAULT_BIAS;
        end else if (word_valid_i) begin
            case (reg_addr)
                REG_GAIN: begin
                    gain_o <= data_i[PIXEL_WIDTH-1:0];
                end
                REG_BIAS: begin
                    bias_o <= data_i[PIXEL_WIDTH-1:0];
                end
                default: begin
                    // unknown address leaves both registers alone
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/contrast_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module contrast_stage (
    input  logic                                  core_clk,
    input  logic                                  sys_reset,
    input  logic [preview_pkg::PIXEL_WIDTH-1:0]   a_i,
    input  logic [preview_pkg::PIXEL_WIDTH-1:0]   b_i,
    input  logic                                  sof_i,
    input  logic                                  valid_i,
    input  logic [preview_pkg::PIXEL_WIDTH-1:0]   gain_i,
    input  logic [preview_pkg::PIXEL_WIDTH-1:0]   bias_i,
    input  logic                                  ready_i,
    output logic                                  ready_o,
    output logic [preview_pkg::PIXEL_WIDTH-1:0]   data_o,
    output logic                                  sof_o,
    output logic                                  valid_o
);
    import preview_pkg::*;

    logic                        accept;
    logic [POS_WIDTH-1:0]        col_q;
    logic [POS_WIDTH-1:0]        row_q;
    logic [POS_WIDTH-1:0]        pix_col;
    logic [POS_WIDTH-1:0]        pix_row;
    logic [PIXEL_WIDTH-1:0]      diff;
    logic [2*PIXEL_WIDTH-1:0]    product;
    logic [2*PIXEL_WIDTH-GAIN_FRAC_BITS:0] sum;
    logic [PIXEL_WIDTH-1:0]      result;

    assign ready_o = !valid_o || ready_i;
    assign accept  = valid_i && ready_o;

    //////////////////////////////
    // position tracking
    //////////////////////////////

    // sof forces this pixel to the origin
    assign pix_col = sof_i ? '0 : col_q;
    assign pix_row = sof_i ? '0 : row_q;

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q <= '0;
            row_q <= '0;
        end else if (accept) begin
            if (pix_col == POS_WIDTH'(ROI_WIDTH - 1)) begin
                col_q <= '0;
                if (pix_row == POS_WIDTH'(ROI_HEIGHT - 1)) begin
                    row_q <= '0;
                end else begin
                    row_q <= pix_row + POS_WIDTH'(1);
                end
            end else begin
                col_q <= pix_col + POS_WIDTH'(1);
                row_q <= pix_row;
            end
        end
    end

    //////////////////////////////
    // contrast rule
    //////////////////////////////

    assign diff    = (a_i > b_i) ? (a_i - b_i) : (b_i - a_i);
    assign product = diff * gain_i;
    assign sum     = {1'b0, product[2*PIXEL_WIDTH-1:GAIN_FRAC_BITS]}
                   + (2*PIXEL_WIDTH-GAIN_FRAC_BITS+1)'(bias_i);
    // clamp to a byte
    assign result  = (sum > (2*PIXEL_WIDTH-GAIN_FRAC_BITS+1)'(255)) ? '1 : sum[PIXEL_WIDTH-1:0];

    // output register holds while downstream stalls
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            valid_o <= 1'b0;
        end else if (accept) begin
            valid_o <= 1'b1;
        end else if (ready_i) begin
            valid_o <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept) begin
            data_o <= result;
            sof_o  <= (pix_col == '0) && (pix_row == '0);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo (
    input  logic                                  core_clk,
    input  logic                                  sys_reset,
    input  logic [preview_pkg::PIXEL_WIDTH-1:0]   wr_data_i,
    input  logic                                  wr_sof_i,
    input  logic                                  wr_valid_i,
    input  logic                                  rd_pop_i,
    output logic                                  wr_ready_o,
    output logic [preview_pkg::PIXEL_WIDTH-1:0]   rd_data_o,
    output logic                                  rd_sof_o,
    output logic                                  rd_valid_o
);
    import preview_pkg::*;

    // each entry is {sof tag, pixel}
    logic [PIXEL_WIDTH:0]       mem [FIFO_DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr_q;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr_q;
    logic [FIFO_ADDR_WIDTH:0]   count_q;
    logic                       push;
    logic                       pop;

    assign wr_ready_o = (count_q != (FIFO_ADDR_WIDTH+1)'(FIFO_DEPTH));
    assign rd_valid_o = (count_q != '0);
    assign push       = wr_valid_i && wr_ready_o;
    assign pop        = rd_pop_i && rd_valid_o;

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr_q] <= {wr_sof_i, wr_data_i};
        end
    end

    //////////////////////////////
    // pointers and occupancy
    //////////////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // show-ahead head entry
    assign rd_sof_o  = mem[rd_ptr_q][PIXEL_WIDTH];
    assign rd_data_o = mem[rd_ptr_q][PIXEL_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== rtl/frame_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_serializer (
    input  logic                                  core_clk,
    input  logic                                  sys_reset,
    input  logic [preview_pkg::PIXEL_WIDTH-1:0]   fifo_data_i,
    input  logic                                  fifo_sof_i,
    input  logic                                  fifo_valid_i,
    input  logic                                  tx_ready_i,
    output logic                                  fifo_pop_o,
    output logic [preview_pkg::PIXEL_WIDTH-1:0]   tx_data_o,
    output logic                                  tx_valid_o
);
    import preview_pkg::*;

    ser_state_e                 state_q;
    logic [HDR_INDEX_WIDTH-1:0] hdr_idx_q;
    logic                       hdr_sent_q;
    logic [PIXEL_WIDTH-1:0]     magic_byte;
    logic                       head_needs_hdr;
    logic                       tx_fire;

    // index 0 picks the top byte
    assign magic_byte = MAGIC_NUM[(MAGIC_BYTES - 1 - int'(hdr_idx_q)) * PIXEL_WIDTH +: PIXEL_WIDTH];

    assign head_needs_hdr = fifo_valid_i && fifo_sof_i && !hdr_sent_q;

    //////////////////////////////
    // byte mux
    //////////////////////////////

    always_comb begin
        if (state_q == HEADER) begin
            tx_valid_o = 1'b1;
            tx_data_o  = magic_byte;
        end else begin
            // frame start pixel waits for its header
            tx_valid_o = fifo_valid_i && !head_needs_hdr;
            tx_data_o  = fifo_data_i;
        end
    end

    assign tx_fire    = tx_valid_o && tx_ready_i;
    assign fifo_pop_o = (state_q == PIXELS) && tx_fire;

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q    <= PIXELS;
            hdr_idx_q  <= '0;
            hdr_sent_q <= 1'b0;
        end else begin
            case (state_q)
                HEADER: begin
                    if (tx_fire) begin
                        if (hdr_idx_q == HDR_INDEX_WIDTH'(MAGIC_BYTES - 1)) begin
                            hdr_idx_q  <= '0;
                            hdr_sent_q <= 1'b1;
                            state_q    <= PIXELS;
                        end else begin
                            hdr_idx_q <= hdr_idx_q + 1'b1;
                        end
                    end
                end
                default: begin
                    if (head_needs_hdr) begin
                        state_q <= HEADER;
                    end else if (tx_fire) begin
                        // header credit is spent on the popped pixel
                        hdr_sent_q <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/preview_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module preview_top (
    input  logic                                  core_clk,
    input  logic                                  sys_reset,
    input  logic [preview_pkg::PIXEL_WIDTH-1:0]   cmd_byte_i,
    input  logic                                  cmd_valid_i,
    input  logic [preview_pkg::PIXEL_WIDTH-1:0]   pixel_a_i,
    input  logic [preview_pkg::PIXEL_WIDTH-1:0]   pixel_b_i,
    input  logic                                  pixel_sof_i,
    input  logic                                  pixel_valid_i,
    input  logic                                  tx_ready_i,
    output logic                                  pixel_ready_o,
    output logic [preview_pkg::PIXEL_WIDTH-1:0]   tx_data_o,
    output logic                                  tx_valid_o
);
    import preview_pkg::*;

    //////////////////////////////
    // command path
    //////////////////////////////

    logic [CMD_ADDR_WIDTH-1:0] cmd_addr;
    logic [CMD_DATA_WIDTH-1:0] cmd_data;
    logic                      cmd_word_valid;
    logic [PIXEL_WIDTH-1:0]    gain;
    logic [PIXEL_WIDTH-1:0]    bias;

    word_concatenator u_word_concatenator (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .byte_i       (cmd_byte_i),
        .byte_valid_i (cmd_valid_i),
        .addr_o       (cmd_addr),
        .data_o       (cmd_data),
        .word_valid_o (cmd_word_valid)
    );

    constants_controller u_constants_controller (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .addr_i       (cmd_addr),
        .data_i       (cmd_data),
        .word_valid_i (cmd_word_valid),
        .gain_o       (gain),
        .bias_o       (bias)
    );

    //////////////////////////////
    // pixel path
    //////////////////////////////

    logic [PIXEL_WIDTH-1:0] px_data;
    logic                   px_sof;
    logic                   px_valid;
    logic                   px_ready;
    logic [PIXEL_WIDTH-1:0] fifo_data;
    logic                   fifo_sof;
    logic                   fifo_valid;
    logic                   fifo_pop;

    contrast_stage u_contrast_stage (
        .core_clk  (core_clk),
        .sys_reset (sys_reset),
        .a_i       (pixel_a_i),
        .b_i       (pixel_b_i),
        .sof_i     (pixel_sof_i),
        .valid_i   (pixel_valid_i),
        .gain_i    (gain),
        .bias_i    (bias),
        .ready_i   (px_ready),
        .ready_o   (pixel_ready_o),
        .data_o    (px_data),
        .sof_o     (px_sof),
        .valid_o   (px_valid)
    );

    stream_fifo u_stream_fifo (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .wr_data_i  (px_data),
        .wr_sof_i   (px_sof),
        .wr_valid_i (px_valid),
        .rd_pop_i   (fifo_pop),
        .wr_ready_o (px_ready),
        .rd_data_o  (fifo_data),
        .rd_sof_o   (fifo_sof),
        .rd_valid_o (fifo_valid)
    );

    // host byte port
    frame_serializer u_frame_serializer (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .fifo_data_i  (fifo_data),
        .fifo_sof_i   (fifo_sof),
        .fifo_valid_i (fifo_valid),
        .tx_ready_i   (tx_ready_i),
        .fifo_pop_o   (fifo_pop),
        .tx_data_o    (tx_data_o),
        .tx_valid_o   (tx_valid_o)
    );

endmodule

`default_nettype wire

// ==== testbench/preview_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module preview_tb;
    import preview_pkg::*;

    localparam int          CLK_PERIOD      = 20;
    localparam int          DRIVE_DELAY     = 2;
    localparam int          RESET_CYCLES    = 4;
    localparam int          CYCLES_PER_REC  = 40;
    localparam logic [15:0] LFSR_SEED       = 16'd93;
    localparam logic [63:0] MAGIC_TEXT      = "BIVFRAME";
    localparam string       VEC_FILE        = "testbench/preview_vectors.txt";

    logic       core_clk;
    logic       sys_reset;
    logic [7:0] cmd_byte_i;
    logic       cmd_valid_i;
    logic [7:0] pixel_a_i;
    logic [7:0] pixel_b_i;
    logic       pixel_sof_i;
    logic       pixel_valid_i;
    logic       tx_ready_i;
    logic       pixel_ready_o;
    logic [7:0] tx_data_o;
    logic       tx_valid_o;

    // bytes the host should see in order
    logic [7:0] exp_q[$];
    string      lines[$];
    string      cur_test = "setup";
    int         record_weight = 0;
    int         test_checks = 0;
    int         test_errors = 0;
    int         total_checks = 0;
    int         total_errors = 0;
    int         tests_done = 0;
    int         model_col = 0;
    int         model_row = 0;
    int         model_gain = DEFAULT_GAIN;
    int         model_bias = DEFAULT_BIAS;
    logic       load_done = 1'b0;
    logic       bp_mode = 1'b0;
    logic       bp_seen = 1'b0;
    logic       test_bp = 1'b0;
    logic [15:0] lfsr_state;

    preview_top dut0 (
        .core_clk      (core_clk),
        .sys_reset     (sys_reset),
        .cmd_byte_i    (cmd_byte_i),
        .cmd_valid_i   (cmd_valid_i),
        .pixel_a_i     (pixel_a_i),
        .pixel_b_i     (pixel_b_i),
        .pixel_sof_i   (pixel_sof_i),
        .pixel_valid_i (pixel_valid_i),
        .tx_ready_i    (tx_ready_i),
        .pixel_ready_o (pixel_ready_o),
        .tx_data_o     (tx_data_o),
        .tx_valid_o    (tx_valid_o)
    );

    initial begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    //////////////////////////////
    // reference models
    //////////////////////////////

    // |a - b| times gain in 4.4 plus bias and clamped to a byte
    function automatic logic [7:0] contrast_ref(input int a, input int b, input int gain,
                                                input int bias);
        int diff;
        int value;
        diff  = (a > b) ? a - b : b - a;
        value = ((diff * gain) >> GAIN_FRAC_BITS) + bias;
        if (value > 255) begin
            value = 255;
        end
        return value[7:0];
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic expect_pixel(input logic [7:0] a, input logic [7:0] b, input int sof,
                                input logic [7:0] file_exp);
        logic [7:0] expected;
        expected = contrast_ref(a, b, model_gain, model_bias);
        assert (expected == file_exp) else begin
            $display("Error: %s expected %02h actual %02h in the vector file",
                     cur_test, expected, file_exp);
            note_error();
        end
        if (sof != 0) begin
            model_col = 0;
            model_row = 0;
        end
        if (model_col == 0 && model_row == 0) begin
            for (int i = 0; i < 8; i++) begin
                exp_q.push_back(MAGIC_TEXT[63 - 8 * i -: 8]);
            end
        end
        exp_q.push_back(expected);
        model_col++;
        if (model_col == ROI_WIDTH) begin
            model_col = 0;
            model_row = (model_row + 1) % ROI_HEIGHT;
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic send_command(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] word;
        word = {addr, data};
        for (int i = 0; i < CMD_BYTES; i++) begin
            cmd_byte_i  = word[47 - 8 * i -: 8];
            cmd_valid_i = 1'b1;
            @(posedge core_clk);
            #DRIVE_DELAY;
        end
        cmd_valid_i = 1'b0;
        // registers settle before the next pixel
        repeat (2) begin
            @(posedge core_clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic send_pixel(input logic [7:0] a, input logic [7:0] b, input logic sof);
        pixel_a_i     = a;
        pixel_b_i     = b;
        pixel_sof_i   = sof;
        pixel_valid_i = 1'b1;
        @(negedge core_clk);
        while (!pixel_ready_o) begin
            @(negedge core_clk);
        end
        @(posedge core_clk);
        #DRIVE_DELAY;
        pixel_valid_i = 1'b0;
        pixel_sof_i   = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
        bp_mode     = 1'b0;
        bp_seen     = 1'b0;
        test_bp     = 1'b0;
    endtask

    task automatic finish_test();
        while (exp_q.size() != 0) begin
            @(posedge core_clk);
            #DRIVE_DELAY;
        end
        if (test_bp) begin
            assert (bp_seen) else begin
                $display("pixel_ready_o never dropped under back-pressure in %s", cur_test);
                note_error();
            end
        end
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        tests_done++;
    endtask

    task automatic load_vectors(output logic ok);
        int         fd;
        int         n;
        int         count;
        logic [7:0] a;
        logic [7:0] b;
        int         sof;
        logic [7:0] file_exp;
        string      line;
        fd = $fopen(VEC_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                // skip comments and blank lines
                if (line.len() >= 2 && line.getc(0) != "#") begin
                    lines.push_back(line);
                    if (line.getc(0) == "P") begin
                        n = $sscanf(line.substr(2, line.len() - 1), "%h %h %d %h %d",
                                    a, b, sof, file_exp, count);
                        record_weight += count;
                    end else begin
                        record_weight++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_records();
        int          n;
        int          count;
        int          sof;
        int          mode;
        byte         kind;
        string       body;
        string       name;
        logic [15:0] addr;
        logic [31:0] data;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  file_exp;
        foreach (lines[k]) begin
            kind = lines[k].getc(0);
            body = lines[k].substr(2, lines[k].len() - 1);
            case (kind)
                "T": begin
                    n = $sscanf(body, "%s", name);
                    finish_test();
                    start_test(name);
                end
                "C": begin
                    n = $sscanf(body, "%h %h", addr, data);
                    if (addr == REG_GAIN) begin
                        model_gain = int'(data[7:0]);
                    end else if (addr == REG_BIAS) begin
                        model_bias = int'(data[7:0]);
                    end
                    send_command(addr, data);
                end
                "M": begin
                    n = $sscanf(body, "%d", mode);
                    bp_mode = (mode != 0);
                    test_bp = test_bp || bp_mode;
                end
                "P": begin
                    n = $sscanf(body, "%h %h %d %h %d", a, b, sof, file_exp, count);
                    for (int j = 0; j < count; j++) begin
                        expect_pixel(a, b, (j == 0) ? sof : 0, file_exp);
                        send_pixel(a, b, (sof != 0) && (j == 0));
                    end
                end
                default: begin
                    $display("unknown record in the vector file: %s", lines[k]);
                    note_error();
                end
            endcase
        end
    endtask

    //////////////////////////////
    // tx port
    //////////////////////////////

    initial begin
        lfsr_state = LFSR_SEED;
        tx_ready_i = 1'b1;
        forever begin
            @(posedge core_clk);
            #DRIVE_DELAY;
            if (bp_mode) begin
                lfsr_state = lfsr_step(lfsr_state);
                tx_ready_i = lfsr_state[0];
            end else begin
                tx_ready_i = 1'b1;
            end
        end
    end

    // sampled mid cycle ahead of the transfer at the next rising edge
    always @(negedge core_clk) begin
        if (!sys_reset) begin
            if (bp_mode && !pixel_ready_o) begin
                bp_seen = 1'b1;
            end
            if (tx_valid_o && tx_ready_i) begin
                assert (exp_q.size() != 0) else begin
                    $display("byte %02h left the tx port with nothing expected in %s",
                             tx_data_o, cur_test);
                    note_error();
                end
                if (exp_q.size() != 0) begin
                    test_checks++;
                    total_checks++;
                    assert (tx_data_o == exp_q[0]) else begin
                        $display("Error: %s expected %02h actual %02h",
                                 cur_test, exp_q[0], tx_data_o);
                        note_error();
                    end
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        wait (load_done);
        repeat (CYCLES_PER_REC * record_weight + 200) @(posedge core_clk);
        $display("Timeout: the run did not end within %0d cycles",
                 CYCLES_PER_REC * record_weight + 200);
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        logic ok;
        sys_reset     = 1'b1;
        cmd_byte_i    = 8'h00;
        cmd_valid_i   = 1'b0;
        pixel_a_i     = 8'h00;
        pixel_b_i     = 8'h00;
        pixel_sof_i   = 1'b0;
        pixel_valid_i = 1'b0;
        load_vectors(ok);
        if (!ok) begin
            $display("could not open %s", VEC_FILE);
            $display("ERRORS FOUND");
            $finish;
        end else begin
            load_done = 1'b1;
            repeat (RESET_CYCLES) @(posedge core_clk);
            #DRIVE_DELAY;
            sys_reset = 1'b0;
            start_test("reset_state");
            @(negedge core_clk);
            assert (tx_valid_o == 1'b0) else begin
                $display("Error: %s expected tx_valid_o 0 actual %0d", cur_test, tx_valid_o);
                note_error();
            end
            assert (pixel_ready_o == 1'b1) else begin
                $display("Error: %s expected pixel_ready_o 1 actual %0d", cur_test,
                         pixel_ready_o);
                note_error();
            end
            test_checks = 2;
            total_checks += 2;
            @(posedge core_clk);
            #DRIVE_DELAY;
            run_records();
            finish_test();
            // stray bytes would show up here
            repeat (20) @(posedge core_clk);
            $display("%0d tests, %0d checks, %0d errors", tests_done, total_checks,
                     total_errors);
            if (total_errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/preview_vectors.txt ====
# P a b sof expected count : pixel pair, a b expected in hex, sof and count in decimal
# C addr data : command word in hex    M mode : 1 drives tx_ready from the LFSR
# T name : starts a new test
T default_frame
P 10 30 1 20 1
P 80 05 0 7b 7
P ff 00 0 ff 8
P 00 ff 0 ff 8
P 42 42 0 00 8
T gain_bias
C 0001 12345630
C 0002 00000010
C 1234 000000ff
P 30 20 1 40 4
P 00 40 0 d0 4
P 60 00 0 ff 4
P 05 00 0 1f 4
C 0001 00000018
P 07 00 0 1a 4
C 0002 000000f8
P 01 00 0 f9 4
P 10 00 0 ff 8
T frame_wrap
C 0001 00000010
C 0002 00000000
P 09 03 0 06 40
T mid_frame_sof
P 20 10 0 10 5
P 11 22 1 11 3
P 01 02 0 01 29
T backpressure
M 1
P 0a 50 1 46 20
P c8 64 0 64 20
P 33 00 0 33 24

// ==== list.f ====
rtl/preview_pkg.sv
rtl/word_concatenator.sv
rtl/constants_controller.sv
rtl/contrast_stage.sv
rtl/stream_fifo.sv
rtl/frame_serializer.sv
rtl/preview_top.sv
testbench/preview_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the preview testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module preview_tb -f list.f &&
./obj_dir/Vpreview_tb | tee /dev/stderr | grep -q "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
